//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    // Operand source picked in decode
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX,
        FWD_MEM
    } fwd_sel_t;

endpackage

`default_nettype wire

//--- decode/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_stall,
    input  logic                          i_flush,
    input  logic                          i_interlock,
    input  logic [rv_pkg::XLEN-1:0]       i_instr,
    input  logic [rv_pkg::XLEN-1:0]       i_pc,
    input  logic                          i_valid,
    input  logic [rv_pkg::XLEN-1:0]       i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       i_rs2_data,
    input  logic [rv_pkg::XLEN-1:0]       i_ex_fwd,
    input  logic [rv_pkg::XLEN-1:0]       i_mem_fwd,
    input  rv_pkg::fwd_sel_t              i_fwd1,
    input  rv_pkg::fwd_sel_t              i_fwd2,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs2,
    output logic                          o_is_load_use_reader,
    output logic [rv_pkg::XLEN-1:0]       o_ex_pc,
    output logic [rv_pkg::XLEN-1:0]       o_ex_a,
    output logic [rv_pkg::XLEN-1:0]       o_ex_b,
    output logic [rv_pkg::XLEN-1:0]       o_ex_imm,
    output rv_pkg::alu_op_t               o_ex_alu_op,
    output rv_pkg::opcode_t               o_ex_opcode,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_ex_rd,
    output logic                          o_ex_reg_we
);
    import rv_pkg::*;

    opcode_t         opcode;
    alu_op_t         alu_op;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm;
    logic            known;
    logic            reg_we;
    logic            bubble;

    function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] pick(input fwd_sel_t sel, input logic [XLEN-1:0] rf,
                                             input logic [XLEN-1:0] ex,
                                             input logic [XLEN-1:0] mem);
        case (sel)
            FWD_EX:  return ex;
            FWD_MEM: return mem;
            default: return rf;
        endcase
    endfunction

    assign opcode = opcode_t'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];
    assign o_is_load_use_reader = (opcode == OP) || (opcode == STORE) || (opcode == BRANCH);

    always_comb begin
        known  = 1'b1;
        reg_we = 1'b0;
        alu_op = ALU_ADD;
        imm    = {{20{i_instr[31]}}, i_instr[31:20]};
        case (opcode)
            OP: begin
                reg_we = 1'b1;
                alu_op = alu_from_funct3(funct3, i_instr[30]);
            end
            OP_IMM: begin
                reg_we = 1'b1;
                alu_op = alu_from_funct3(funct3, 1'b0);
            end
            LUI: begin
                reg_we = 1'b1;
                alu_op = ALU_PASS_B;
                imm    = {i_instr[31:12], 12'b0};
            end
            LOAD: reg_we = 1'b1;
            STORE: imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            BRANCH: begin
                // BNE travels as ALU_XOR
                alu_op = funct3[0] ? ALU_XOR : ALU_SUB;
                imm    = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                          i_instr[30:25], i_instr[11:8], 1'b0};
            end
            JAL: begin
                reg_we = 1'b1;
                imm    = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                          i_instr[20], i_instr[30:21], 1'b0};
            end
            default: known = 1'b0;
        endcase
    end

    assign bubble = i_stall || i_flush || !i_valid || !known;

    // ID/EX control
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_ex_reg_we <= 1'b0;
            o_ex_opcode <= OP_IMM;
        end else if (!i_interlock) begin
            o_ex_reg_we <= reg_we && !bubble;
            o_ex_opcode <= bubble ? OP_IMM : opcode;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_interlock) begin
            o_ex_pc     <= i_pc;
            o_ex_a      <= pick(i_fwd1, i_rs1_data, i_ex_fwd, i_mem_fwd);
            o_ex_b      <= pick(i_fwd2, i_rs2_data, i_ex_fwd, i_mem_fwd);
            o_ex_imm    <= imm;
            o_ex_alu_op <= alu_op;
            o_ex_rd     <= i_instr[11:7];
        end
    end

endmodule

`default_nettype wire

//--- dv/core_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module core_assertions (
    input logic        clk,
    input logic        i_reset,
    input logic        i_mreq,
    input logic        i_write,
    input logic [31:0] i_dad,
    input logic        i_ackd_n,
    input logic        i_stall,
    input logic        i_flush
);

    int violations = 0;

    // A data access waiting for its acknowledge keeps request, direction and address
    assert property (@(posedge clk) disable iff (i_reset) i_mreq && i_ackd_n |=> i_mreq)
    else begin
        $error("o_mreq dropped before the access was acknowledged");
        violations++;
    end

    assert property (@(posedge clk) disable iff (i_reset)
                     i_mreq && i_ackd_n |=> $stable(i_write))
    else begin
        $error("o_write changed before the access was acknowledged");
        violations++;
    end

    assert property (@(posedge clk) disable iff (i_reset)
                     i_mreq && i_ackd_n |=> $stable(i_dad))
    else begin
        $error("o_dad changed before the access was acknowledged");
        violations++;
    end

    // Load in EX and a taken jump in EX cannot both be true
    assert property (@(posedge clk) disable iff (i_reset) !(i_stall && i_flush))
    else begin
        $error("load-use stall and branch flush raised together");
        violations++;
    end

endmodule

bind core_top core_assertions u_core_assertions (
    .clk(clk),
    .i_reset(i_reset),
    .i_mreq(o_mreq),
    .i_write(o_write),
    .i_dad(o_dad),
    .i_ackd_n(i_ackd_n),
    .i_stall(stall),
    .i_flush(flush)
);

`default_nettype wire

//--- dv/core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module core_tb;

    localparam logic [31:0] RESET_PC   = 32'h0;
    localparam int          PROG_LEN   = 42;
    localparam int          NUM_STORES = 13;

    localparam logic [6:0] OPC_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [2:0] F3_ADD   = 3'b000;
    localparam logic [2:0] F3_SLT   = 3'b010;
    localparam logic [2:0] F3_XOR   = 3'b100;
    localparam logic [2:0] F3_OR    = 3'b110;
    localparam logic [2:0] F3_AND   = 3'b111;
    localparam logic [2:0] F3_LW    = 3'b010;
    localparam logic [2:0] F3_BEQ   = 3'b000;
    localparam logic [2:0] F3_BNE   = 3'b001;

    logic        clk      = 1'b0;
    logic        i_reset  = 1'b1;
    logic        i_acki_n = 1'b1;
    logic        i_ackd_n = 1'b1;
    logic [31:0] i_idt;
    logic [31:0] i_ddt;
    logic [31:0] o_iad;
    logic [31:0] o_dad;
    logic [31:0] o_ddt;
    logic        o_mreq;
    logic        o_write;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    logic [31:0] prog [PROG_LEN];
    // Store address in the upper half and store data in the lower half
    logic [63:0] exp_store [NUM_STORES];
    int          store_idx = 0;
    int          iwait     = 0;
    int          dwait     = 0;
    integer      seed      = 21261;

    core_top #(
        .RESET_PC(RESET_PC)
    ) u_core_top (
        .clk(clk),
        .i_reset(i_reset),
        .o_iad(o_iad),
        .i_idt(i_idt),
        .i_acki_n(i_acki_n),
        .o_dad(o_dad),
        .o_ddt(o_ddt),
        .i_ddt(i_ddt),
        .o_mreq(o_mreq),
        .o_write(o_write),
        .i_ackd_n(i_ackd_n)
    );

    always #2 clk = ~clk;

    // Both memories answer combinationally and only the acknowledge waits
    assign i_idt = imem[o_iad[7:2]];
    assign i_ddt = dmem[o_dad[9:2]];

    function automatic logic [31:0] reg_reg_op(input logic [2:0] f3, input logic [6:0] f7,
                                               input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_op(input logic [6:0] opc, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] store_word(input int rs2, input int rs1, input int imm);
        logic [11:0] off;
        off = 12'(imm);
        return {off[11:5], 5'(rs2), 5'(rs1), 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_op(input logic [2:0] f3, input int rs1, input int rs2,
                                              input int imm);
        logic [12:0] off;
        off = 13'(imm);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] lui_op(input int rd, input int imm);
        return {20'(imm), 5'(rd), 7'b0110111};
    endfunction

    function automatic logic [31:0] jal_op(input int rd, input int imm);
        logic [20:0] off;
        off = 21'(imm);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error: time %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // Random wait states of at most two in a row
    always @(posedge clk) begin
        if (iwait < 2 && ($random(seed) & 1)) begin
            i_acki_n <= 1'b1;
            iwait    <= iwait + 1;
        end else begin
            i_acki_n <= 1'b0;
            iwait    <= 0;
        end
        if (dwait < 2 && ($random(seed) & 1)) begin
            i_ackd_n <= 1'b1;
            dwait    <= dwait + 1;
        end else begin
            i_ackd_n <= 1'b0;
            dwait    <= 0;
        end
    end

    // Completed stores are compared in order
    always @(negedge clk) begin
        if (!i_reset && o_mreq && o_write && !i_ackd_n) begin
            if (store_idx >= NUM_STORES) begin
                $display("unexpected store to address %h after the last expected store", o_dad);
                $display("*** FAILED ***");
                $fatal(1, "extra store");
            end else begin
                check_value("store address", o_dad, exp_store[store_idx][63:32]);
                check_value("store data", o_ddt, exp_store[store_idx][31:0]);
                dmem[o_dad[9:2]] = o_ddt;
                store_idx = store_idx + 1;
            end
        end
    end

    always @(negedge clk) begin
        if (u_core_top.u_core_assertions.violations != 0) begin
            $display("a bus or hazard assertion failed, see the assertion report above");
            $display("*** FAILED ***");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        repeat (40 * (PROG_LEN + NUM_STORES)) @(posedge clk);
        $display("timeout: the program did not finish, %0d of %0d stores seen",
                 store_idx, NUM_STORES);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        // Dependent ALU chain with x10 as the store base
        prog[0]  = imm_op(OPC_IMM, F3_ADD, 10, 0, 'h100);
        prog[1]  = imm_op(OPC_IMM, F3_ADD, 1, 0, 5);
        prog[2]  = imm_op(OPC_IMM, F3_ADD, 2, 1, 7);
        prog[3]  = reg_reg_op(F3_ADD, 7'h00, 3, 1, 2);
        prog[4]  = reg_reg_op(F3_ADD, 7'h20, 4, 1, 3);
        prog[5]  = reg_reg_op(F3_AND, 7'h00, 5, 4, 3);
        prog[6]  = reg_reg_op(F3_OR, 7'h00, 6, 5, 1);
        prog[7]  = reg_reg_op(F3_XOR, 7'h00, 7, 6, 2);
        prog[8]  = reg_reg_op(F3_SLT, 7'h00, 8, 4, 1);
        prog[9]  = store_word(3, 10, 0);
        prog[10] = store_word(4, 10, 4);
        prog[11] = store_word(5, 10, 8);
        prog[12] = store_word(6, 10, 12);
        prog[13] = store_word(7, 10, 16);
        prog[14] = store_word(8, 10, 20);
        prog[15] = imm_op(OPC_IMM, F3_AND, 11, 7, 'h00f);
        prog[16] = imm_op(OPC_IMM, F3_OR, 12, 11, 'h030);
        prog[17] = imm_op(OPC_IMM, F3_XOR, 13, 12, -1);
        prog[18] = store_word(13, 10, 24);
        // Load followed at once by its use
        prog[19] = imm_op(OPC_LOAD, F3_LW, 14, 10, 'h100);
        prog[20] = imm_op(OPC_IMM, F3_ADD, 15, 14, 3);
        prog[21] = store_word(15, 10, 28);
        prog[22] = imm_op(OPC_LOAD, F3_LW, 16, 10, 0);
        prog[23] = reg_reg_op(F3_ADD, 7'h00, 17, 16, 16);
        prog[24] = store_word(17, 10, 32);
        // Branches whose skipped stores must never appear
        prog[25] = branch_op(F3_BEQ, 1, 2, 8);
        prog[26] = branch_op(F3_BNE, 1, 2, 12);
        prog[27] = store_word(1, 10, 36);
        prog[28] = store_word(1, 10, 36);
        prog[29] = branch_op(F3_BEQ, 2, 2, 8);
        prog[30] = store_word(2, 10, 36);
        prog[31] = branch_op(F3_BNE, 3, 3, 8);
        prog[32] = store_word(11, 10, 36);
        prog[33] = jal_op(18, 12);
        prog[34] = store_word(1, 10, 40);
        prog[35] = store_word(1, 10, 40);
        prog[36] = store_word(18, 10, 40);
        prog[37] = imm_op(OPC_IMM, F3_ADD, 0, 0, 99);
        prog[38] = store_word(0, 10, 44);
        prog[39] = lui_op(19, 'habcde);
        prog[40] = store_word(19, 10, 48);
        prog[41] = jal_op(0, 0);

        exp_store[0]  = {32'h0000_0100, 32'h0000_0011};
        exp_store[1]  = {32'h0000_0104, 32'hffff_fff4};
        exp_store[2]  = {32'h0000_0108, 32'h0000_0010};
        exp_store[3]  = {32'h0000_010c, 32'h0000_0015};
        exp_store[4]  = {32'h0000_0110, 32'h0000_0019};
        exp_store[5]  = {32'h0000_0114, 32'h0000_0001};
        exp_store[6]  = {32'h0000_0118, 32'hffff_ffc6};
        exp_store[7]  = {32'h0000_011c, 32'hc0de_0083};
        exp_store[8]  = {32'h0000_0120, 32'h0000_0022};
        exp_store[9]  = {32'h0000_0124, 32'h0000_0009};
        exp_store[10] = {32'h0000_0128, 32'h0000_0088};
        exp_store[11] = {32'h0000_012c, 32'h0000_0000};
        exp_store[12] = {32'h0000_0130, 32'habcd_e000};

        // Unused words are NOPs that carry their own index
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < PROG_LEN) ? prog[i] : imm_op(OPC_IMM, F3_ADD, 0, 0, i);
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = {16'hc0de, 16'(i)};
        end

        repeat (4) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        check_value("o_iad after reset", o_iad, RESET_PC);
        check_value("o_mreq after reset", {31'b0, o_mreq}, 32'h0);

        wait (store_idx == NUM_STORES);
        // Let the final jump loop spin a little to expose late stores
        repeat (10) @(posedge clk);
        @(negedge clk);
        if (u_core_top.u_core_assertions.violations == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("a bus or hazard assertion failed near the end of the program");
            $display("*** FAILED ***");
            $fatal(1, "assertion failure");
        end
    end

endmodule

`default_nettype wire

//--- execute/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_interlock,
    input  logic [rv_pkg::XLEN-1:0]       i_pc,
    input  logic [rv_pkg::XLEN-1:0]       i_a,
    input  logic [rv_pkg::XLEN-1:0]       i_b,
    input  logic [rv_pkg::XLEN-1:0]       i_imm,
    input  rv_pkg::alu_op_t               i_alu_op,
    input  rv_pkg::opcode_t               i_opcode,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic                          i_reg_we,
    output logic                          o_jump,
    output logic [rv_pkg::XLEN-1:0]       o_jump_target,
    output logic [rv_pkg::XLEN-1:0]       o_ex_fwd,
    output logic [rv_pkg::XLEN-1:0]       o_mem_result,
    output logic [rv_pkg::XLEN-1:0]       o_mem_store_data,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_mem_rd,
    output rv_pkg::opcode_t               o_mem_opcode,
    output logic                          o_mem_reg_we
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            taken;

    assign op_b = (i_opcode == OP) ? i_b : i_imm;

    always_comb begin
        case (i_alu_op)
            ALU_SUB:    alu_result = i_a - op_b;
            ALU_AND:    alu_result = i_a & op_b;
            ALU_OR:     alu_result = i_a | op_b;
            ALU_XOR:    alu_result = i_a ^ op_b;
            ALU_SLT:    alu_result = XLEN'($signed(i_a) < $signed(op_b));
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = i_a + op_b;
        endcase
    end

    // BEQ as ALU_SUB, BNE as ALU_XOR
    assign taken = (i_a == i_b) ^ (i_alu_op == ALU_XOR);

    assign o_jump        = (i_opcode == JAL) || ((i_opcode == BRANCH) && taken);
    assign o_jump_target = i_pc + i_imm;
    assign o_ex_fwd      = (i_opcode == JAL) ? i_pc + XLEN'(4) : alu_result;

    // EX/MEM
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_mem_reg_we <= 1'b0;
            o_mem_opcode <= OP_IMM;
        end else if (!i_interlock) begin
            o_mem_reg_we <= i_reg_we;
            o_mem_opcode <= i_opcode;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_interlock) begin
            o_mem_result     <= o_ex_fwd;
            o_mem_store_data <= i_b;
            o_mem_rd         <= i_rd;
        end
    end

endmodule

`default_nettype wire

//--- fetch/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_stall,
    input  logic                    i_flush,
    input  logic                    i_interlock,
    input  logic [rv_pkg::XLEN-1:0] i_jump_target,
    input  logic [rv_pkg::XLEN-1:0] i_idt,
    output logic [rv_pkg::XLEN-1:0] o_pc,
    output logic [rv_pkg::XLEN-1:0] o_id_pc,
    output logic [rv_pkg::XLEN-1:0] o_id_instr,
    output logic                    o_id_valid
);
    import rv_pkg::*;

    // PC and IF/ID valid bit
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_pc       <= RESET_PC;
            o_id_valid <= 1'b0;
        end else if (!i_interlock) begin
            if (i_flush) begin
                // Word fetched this cycle is on the wrong path
                o_pc       <= i_jump_target;
                o_id_valid <= 1'b0;
            end else if (!i_stall) begin
                o_pc       <= o_pc + XLEN'(4);
                o_id_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_interlock && !i_stall) begin
            o_id_pc    <= o_pc;
            o_id_instr <= i_idt;
        end
    end

endmodule

`default_nettype wire

//--- memory/mem_wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_interlock,
    input  logic [rv_pkg::XLEN-1:0]       i_result,
    input  logic [rv_pkg::XLEN-1:0]       i_store_data,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  rv_pkg::opcode_t               i_opcode,
    input  logic                          i_reg_we,
    input  logic [rv_pkg::XLEN-1:0]       i_ddt,
    input  logic                          i_ackd_n,
    output logic [rv_pkg::XLEN-1:0]       o_dad,
    output logic [rv_pkg::XLEN-1:0]       o_ddt,
    output logic                          o_mreq,
    output logic                          o_write,
    output logic                          o_busy,
    output logic [rv_pkg::XLEN-1:0]       o_mem_fwd,
    output logic                          o_wb_we,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [rv_pkg::XLEN-1:0]       o_wb_data
);
    import rv_pkg::*;

    logic            is_load;
    logic            acc_done;
    logic [XLEN-1:0] ld_data;

    assign is_load = (i_opcode == LOAD);

    assign o_dad   = i_result;
    assign o_ddt   = i_store_data;
    assign o_mreq  = (is_load || (i_opcode == STORE)) && !acc_done;
    assign o_write = (i_opcode == STORE) && !acc_done;
    assign o_busy  = o_mreq && i_ackd_n;

    // Access acked while fetch still holds the pipeline, so do not issue it again
    always_ff @(posedge clk) begin
        if (i_reset || !i_interlock) begin
            acc_done <= 1'b0;
        end else if (o_mreq && !i_ackd_n) begin
            acc_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_mreq && !i_ackd_n) begin
            ld_data <= i_ddt;
        end
    end

    assign o_mem_fwd = !is_load ? i_result :
                       acc_done ? ld_data : i_ddt;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_wb_we <= 1'b0;
        end else if (!i_interlock) begin
            o_wb_we <= i_reg_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_interlock) begin
            o_wb_rd   <= i_rd;
            o_wb_data <= o_mem_fwd;
        end
    end

endmodule

`default_nettype wire

//--- source/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    i_reset,
    output logic [rv_pkg::XLEN-1:0] o_iad,
    input  logic [rv_pkg::XLEN-1:0] i_idt,
    input  logic                    i_acki_n,
    output logic [rv_pkg::XLEN-1:0] o_dad,
    output logic [rv_pkg::XLEN-1:0] o_ddt,
    input  logic [rv_pkg::XLEN-1:0] i_ddt,
    output logic                    o_mreq,
    output logic                    o_write,
    input  logic                    i_ackd_n
);
    import rv_pkg::*;

    logic                  stall;
    logic                  flush;
    logic                  interlock;
    fwd_sel_t              fwd1;
    fwd_sel_t              fwd2;

    // IF/ID
    logic [XLEN-1:0]       id_pc;
    logic [XLEN-1:0]       id_instr;
    logic                  id_valid;
    logic [REG_ADDR_W-1:0] id_rs1;
    logic [REG_ADDR_W-1:0] id_rs2;
    logic                  id_uses_rs2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    // ID/EX
    logic [XLEN-1:0]       ex_pc;
    logic [XLEN-1:0]       ex_a;
    logic [XLEN-1:0]       ex_b;
    logic [XLEN-1:0]       ex_imm;
    alu_op_t               ex_alu_op;
    opcode_t               ex_opcode;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic                  ex_reg_we;
    logic                  jump;
    logic [XLEN-1:0]       jump_target;
    logic [XLEN-1:0]       ex_fwd;

    // EX/MEM and MEM/WB
    logic [XLEN-1:0]       mem_result;
    logic [XLEN-1:0]       mem_store_data;
    logic [REG_ADDR_W-1:0] mem_rd;
    opcode_t               mem_opcode;
    logic                  mem_reg_we;
    logic                  mem_busy;
    logic [XLEN-1:0]       mem_fwd;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch_stage (
        .clk,
        .i_reset,
        .i_stall(stall),
        .i_flush(flush),
        .i_interlock(interlock),
        .i_jump_target(jump_target),
        .i_idt,
        .o_pc(o_iad),
        .o_id_pc(id_pc),
        .o_id_instr(id_instr),
        .o_id_valid(id_valid)
    );

    decode_stage u_decode_stage (
        .clk,
        .i_reset,
        .i_stall(stall),
        .i_flush(flush),
        .i_interlock(interlock),
        .i_instr(id_instr),
        .i_pc(id_pc),
        .i_valid(id_valid),
        .i_rs1_data(rs1_data),
        .i_rs2_data(rs2_data),
        .i_ex_fwd(ex_fwd),
        .i_mem_fwd(mem_fwd),
        .i_fwd1(fwd1),
        .i_fwd2(fwd2),
        .o_rs1(id_rs1),
        .o_rs2(id_rs2),
        .o_is_load_use_reader(id_uses_rs2),
        .o_ex_pc(ex_pc),
        .o_ex_a(ex_a),
        .o_ex_b(ex_b),
        .o_ex_imm(ex_imm),
        .o_ex_alu_op(ex_alu_op),
        .o_ex_opcode(ex_opcode),
        .o_ex_rd(ex_rd),
        .o_ex_reg_we(ex_reg_we)
    );

    reg_file u_reg_file (
        .clk,
        .i_reset,
        .i_rs1(id_rs1),
        .i_rs2(id_rs2),
        .i_we(wb_we),
        .i_rd(wb_rd),
        .i_wdata(wb_data),
        .o_rs1_data(rs1_data),
        .o_rs2_data(rs2_data)
    );

    execute_stage u_execute_stage (
        .clk,
        .i_reset,
        .i_interlock(interlock),
        .i_pc(ex_pc),
        .i_a(ex_a),
        .i_b(ex_b),
        .i_imm(ex_imm),
        .i_alu_op(ex_alu_op),
        .i_opcode(ex_opcode),
        .i_rd(ex_rd),
        .i_reg_we(ex_reg_we),
        .o_jump(jump),
        .o_jump_target(jump_target),
        .o_ex_fwd(ex_fwd),
        .o_mem_result(mem_result),
        .o_mem_store_data(mem_store_data),
        .o_mem_rd(mem_rd),
        .o_mem_opcode(mem_opcode),
        .o_mem_reg_we(mem_reg_we)
    );

    mem_wb_stage u_mem_wb_stage (
        .clk,
        .i_reset,
        .i_interlock(interlock),
        .i_result(mem_result),
        .i_store_data(mem_store_data),
        .i_rd(mem_rd),
        .i_opcode(mem_opcode),
        .i_reg_we(mem_reg_we),
        .i_ddt,
        .i_ackd_n,
        .o_dad,
        .o_ddt,
        .o_mreq,
        .o_write,
        .o_busy(mem_busy),
        .o_mem_fwd(mem_fwd),
        .o_wb_we(wb_we),
        .o_wb_rd(wb_rd),
        .o_wb_data(wb_data)
    );

    hazard_unit u_hazard_unit (
        .i_id_rs1(id_rs1),
        .i_id_rs2(id_rs2),
        .i_id_uses_rs2(id_uses_rs2),
        .i_ex_rd(ex_rd),
        .i_ex_reg_we(ex_reg_we),
        .i_ex_opcode(ex_opcode),
        .i_mem_rd(mem_rd),
        .i_mem_reg_we(mem_reg_we),
        .i_jump(jump),
        .i_acki_n,
        .i_mem_busy(mem_busy),
        .o_fwd1(fwd1),
        .o_fwd2(fwd2),
        .o_stall(stall),
        .o_flush(flush),
        .o_interlock(interlock)
    );

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_id_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_id_rs2,
    input  logic                          i_id_uses_rs2,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_ex_rd,
    input  logic                          i_ex_reg_we,
    input  rv_pkg::opcode_t               i_ex_opcode,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_mem_rd,
    input  logic                          i_mem_reg_we,
    input  logic                          i_jump,
    input  logic                          i_acki_n,
    input  logic                          i_mem_busy,
    output rv_pkg::fwd_sel_t              o_fwd1,
    output rv_pkg::fwd_sel_t              o_fwd2,
    output logic                          o_stall,
    output logic                          o_flush,
    output logic                          o_interlock
);
    import rv_pkg::*;

    logic ex_writes;
    logic mem_writes;

    // The younger result in EX wins over MEM
    function automatic fwd_sel_t fwd_for(input logic ex_hit, input logic mem_hit);
        if (ex_hit) begin
            return FWD_EX;
        end
        if (mem_hit) begin
            return FWD_MEM;
        end
        return FWD_REG;
    endfunction

    assign ex_writes  = i_ex_reg_we && (i_ex_rd != '0);
    assign mem_writes = i_mem_reg_we && (i_mem_rd != '0);

    assign o_fwd1 = fwd_for(ex_writes && (i_ex_rd == i_id_rs1),
                            mem_writes && (i_mem_rd == i_id_rs1));
    assign o_fwd2 = fwd_for(ex_writes && (i_ex_rd == i_id_rs2),
                            mem_writes && (i_mem_rd == i_id_rs2));

    // Load data is not ready until MEM
    assign o_stall = ex_writes && (i_ex_opcode == LOAD) &&
                     ((i_ex_rd == i_id_rs1) || (i_id_uses_rs2 && (i_ex_rd == i_id_rs2)));

    assign o_flush     = i_jump;
    assign o_interlock = i_acki_n || i_mem_busy;

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2,
    input  logic                          i_we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [rv_pkg::XLEN-1:0]       i_wdata,
    output logic [rv_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]       o_rs2_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31];
    logic            wr_en;

    // x0 has no storage
    assign wr_en = i_we && !i_reset && (i_rd != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // Write-through so WB reaches decode in the same cycle
    assign o_rs1_data = (i_rs1 == '0) ? '0 :
                        (wr_en && i_rs1 == i_rd) ? i_wdata : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 :
                        (wr_en && i_rs2 == i_rd) ? i_wdata : regs[i_rs2];

endmodule

`default_nettype wire

//--- verilog.f
common/rv_pkg.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
source/reg_file.sv
execute/execute_stage.sv
source/hazard_unit.sv
memory/mem_wb_stage.sv
source/core_top.sv
dv/core_assertions.sv
dv/core_tb.sv
